/* Makefile */
# Verilator build and run for the dot-matrix controller testbench

VERILATOR ?= verilator
TOP       ?= tb_dot_matrix_ctrl
FILELIST  ?= dot_matrix_ctrl.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dot_matrix_ctrl.f */
+incdir+.
dot_matrix_pkg.sv
dz_regs.sv
scan_timer.sv
glyph_gen.sv
matrix_driver.sv
dot_matrix_ctrl.sv
tb_dot_matrix_ctrl.sv

/* dot_matrix_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dot_matrix_ctrl (
    input  wire                            clk,
    input  wire                            rst,
    input  wire dot_matrix_pkg::axi_addr_t awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire dot_matrix_pkg::axi_data_t wdata,
    input  wire [3:0]                      wstrb,
    input  wire                            wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire dot_matrix_pkg::axi_addr_t araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output dot_matrix_pkg::axi_data_t      rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire                            rready,
    output dot_matrix_pkg::line_t          row,
    output dot_matrix_pkg::line_t          colr,
    output dot_matrix_pkg::line_t          colg
);
    import dot_matrix_pkg::*;

    row_idx_t   row_idx;
    glyph_num_t glyph_num;
    logic       red_en;
    logic       green_en;
    frame_t     frame;

    dz_regs u_dz_regs (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .row_idx   (row_idx),
        .glyph_num (glyph_num),
        .red_en    (red_en),
        .green_en  (green_en)
    );

    scan_timer u_scan_timer (
        .clk     (clk),
        .rst     (rst),
        .tick    (),            // row pacing only
        .row_idx (row_idx)
    );

    glyph_gen u_glyph_gen (
        .glyph_num (glyph_num),
        .frame     (frame)
    );

    matrix_driver u_matrix_driver (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame),
        .row_idx  (row_idx),
        .red_en   (red_en),
        .green_en (green_en),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

endmodule

`default_nettype wire

/* dot_matrix_defs.svh */
`ifndef DOT_MATRIX_DEFS_SVH
`define DOT_MATRIX_DEFS_SVH

// clock cycles each row stays lit, 2 or more
`define DZ_SCAN_DIV 4

// AXI4-Lite byte address width
`define DZ_ADDR_W 4

// register offsets
`define DZ_CTRL_ADDR 4'h0
`define DZ_STAT_ADDR 4'h4

`endif

/* dot_matrix_pkg.sv */
`default_nettype none

`include "dot_matrix_defs.svh"

package dot_matrix_pkg;

    typedef logic [2:0] glyph_num_t;
    typedef logic [2:0] row_idx_t;

    typedef logic [7:0] line_t;     // bit i drives column i
    typedef logic [63:0] frame_t;   // row r sits in bits 8r+7:8r

    typedef logic [`DZ_ADDR_W-1:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    // write side of the register block
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_HAVE_ADDR,
        WR_HAVE_DATA,
        WR_RESP
    } wr_state_t;

endpackage

`default_nettype wire

/* dz_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module dz_regs (
    input  wire                            clk,
    input  wire                            rst,
    input  wire dot_matrix_pkg::axi_addr_t awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire dot_matrix_pkg::axi_data_t wdata,
    input  wire [3:0]                      wstrb,
    input  wire                            wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire dot_matrix_pkg::axi_addr_t araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output dot_matrix_pkg::axi_data_t      rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire                            rready,
    input  wire dot_matrix_pkg::row_idx_t  row_idx,
    output dot_matrix_pkg::glyph_num_t     glyph_num,
    output logic                           red_en,
    output logic                           green_en
);
    import dot_matrix_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    wr_state_t wr_state;
    wr_state_t wr_state_nxt;
    axi_addr_t aw_addr_q;
    axi_data_t w_data_q;
    logic      w_strb0_q;
    axi_addr_t wr_addr;
    axi_data_t wr_data;
    logic      wr_strb0;
    logic      wr_commit;
    logic      aw_hs;
    logic      w_hs;
    logic      ar_hs;
    axi_data_t rd_data;
    logic [1:0] rd_resp;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    assign bvalid = (wr_state == WR_RESP);

    // a channel taken this very cycle bypasses its holding register
    assign wr_addr  = aw_hs ? awaddr : aw_addr_q;
    assign wr_data  = w_hs ? wdata : w_data_q;
    assign wr_strb0 = w_hs ? wstrb[0] : w_strb0_q;

    assign wr_commit = (wr_state != WR_RESP) && (wr_state_nxt == WR_RESP);

    always_comb
    begin
        wr_state_nxt = wr_state;
        case (wr_state)
            WR_IDLE:
            begin
                if (aw_hs && w_hs)
                    wr_state_nxt = WR_RESP;
                else if (aw_hs)
                    wr_state_nxt = WR_HAVE_ADDR;
                else if (w_hs)
                    wr_state_nxt = WR_HAVE_DATA;
            end
            WR_HAVE_ADDR:
                if (w_hs)
                    wr_state_nxt = WR_RESP;
            WR_HAVE_DATA:
                if (aw_hs)
                    wr_state_nxt = WR_RESP;
            default:
                if (bready)
                    wr_state_nxt = WR_IDLE;
        endcase
    end

    // ready follows the state we move into, low during B back-pressure
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_state <= WR_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
        end
        else
        begin
            wr_state <= wr_state_nxt;
            awready  <= (wr_state_nxt == WR_IDLE) || (wr_state_nxt == WR_HAVE_DATA);
            wready   <= (wr_state_nxt == WR_IDLE) || (wr_state_nxt == WR_HAVE_ADDR);
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_hs)
            aw_addr_q <= awaddr;
        if (w_hs)
        begin
            w_data_q  <= wdata;
            w_strb0_q <= wstrb[0];
        end
        if (wr_commit)
            bresp <= (wr_addr == `DZ_CTRL_ADDR) ? RESP_OKAY : RESP_SLVERR;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            glyph_num <= '0;
            red_en    <= 1'b0;
            green_en  <= 1'b0;
        end
        else if (wr_commit && (wr_addr == `DZ_CTRL_ADDR) && wr_strb0)
        begin
            glyph_num <= wr_data[2:0];
            red_en    <= wr_data[4];
            green_en  <= wr_data[5];
        end
    end

    always_comb
    begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            `DZ_CTRL_ADDR: rd_data = {26'd0, green_en, red_en, 1'b0, glyph_num};
            `DZ_STAT_ADDR: rd_data = {29'd0, row_idx};
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end
        else if (ar_hs)
        begin
            rvalid  <= 1'b1;
            arready <= 1'b0;
        end
        else if (rvalid && rready)
        begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end
        else
            arready <= !rvalid;
    end

    // response payload, frozen while rvalid waits
    always_ff @(posedge clk)
    begin
        if (ar_hs)
        begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

/* glyph_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_gen (
    input  wire dot_matrix_pkg::glyph_num_t glyph_num,
    output dot_matrix_pkg::frame_t          frame
);
    import dot_matrix_pkg::*;

    // one pixel of glyph n at row r, column c
    function automatic logic pixel_on(input glyph_num_t n, input int r, input int c);
        int lo;
        int hi;
        lo = 4 - int'(n);
        hi = 3 + int'(n);
        if (n == glyph_num_t'(0))
            return 1'b0;                        // blank
        else if (n <= glyph_num_t'(4))
            return (r >= lo) && (r <= hi) && (c >= lo) && (c <= hi);
        else
            return (r == 0) || (r == 7) || (c == 0) || (c == 7); // border
    endfunction

    line_t rows [8];

    always_comb
    begin
        for (int r = 0; r < 8; r++)
        begin
            for (int c = 0; c < 8; c++)
            begin
                rows[r][c] = pixel_on(glyph_num, r, c);
            end
        end
    end

    always_comb
    begin
        for (int r = 0; r < 8; r++)
        begin
            frame[8*r +: 8] = rows[r];
        end
    end

endmodule

`default_nettype wire

/* matrix_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_driver (
    input  wire                           clk,
    input  wire                           rst,
    input  wire dot_matrix_pkg::frame_t   frame,
    input  wire dot_matrix_pkg::row_idx_t row_idx,
    input  wire                           red_en,
    input  wire                           green_en,
    output dot_matrix_pkg::line_t         row,
    output dot_matrix_pkg::line_t         colr,
    output dot_matrix_pkg::line_t         colg
);
    import dot_matrix_pkg::*;

    line_t sel_line;
    line_t row_sel;

    assign sel_line = frame[8*row_idx +: 8];
    assign row_sel  = ~(line_t'(1) << row_idx); // one zero, active low

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;     // nothing selected
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= row_sel;
            colr <= red_en ? sel_line : '0;
            colg <= green_en ? sel_line : '0;
        end
    end

endmodule

`default_nettype wire

/* scan_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module scan_timer (
    input  wire                          clk,
    input  wire                          rst,
    output logic                         tick,
    output dot_matrix_pkg::row_idx_t     row_idx
);
    import dot_matrix_pkg::*;

    localparam int DIV_W = $clog2(`DZ_SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;

    assign tick = (div_cnt == DIV_W'(`DZ_SCAN_DIV - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // multiplexing clock of the display
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (tick)
        begin
            if (row_idx == row_idx_t'(7))
                row_idx <= '0;
            else
                row_idx <= row_idx + row_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

/* tb_dot_matrix_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_matrix_defs.svh"

module tb_dot_matrix_ctrl;
    import dot_matrix_pkg::*;

    localparam int FRAME_CYCLES   = 8 * `DZ_SCAN_DIV;
    localparam int TIMEOUT_CYCLES = 3000;   // 8 glyphs x 3 frames x 32 plus bus traffic
    localparam int ORDER_BOTH     = 0;
    localparam int AW_FIRST       = 1;
    localparam int W_FIRST        = 2;
    localparam int RD_CTRL        = 0;
    localparam int RD_STAT        = 1;
    localparam int RD_BAD         = 2;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic       clk;
    logic       rst;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    line_t      row;
    line_t      colr;
    line_t      colg;

    int         seed = 23;
    int         cycle_cnt;
    int         rd_kind;
    glyph_num_t exp_glyph;
    logic       exp_red;
    logic       exp_green;
    logic [1:0] exp_bresp;
    logic [1:0] blank_cnt;
    logic       rst_d;
    logic       bvalid_d;
    logic       rvalid_d;
    logic       wr_hits_ctrl;
    axi_data_t  wr_data_m;
    row_idx_t   pin_idx;
    line_t      exp_line;
    line_t      exp_colr;
    line_t      exp_colg;
    axi_data_t  exp_ctrl_word;
    line_t      row_d;

    dot_matrix_ctrl u_dot_matrix_ctrl (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

    always #20 clk = ~clk;

    // expected pixels of glyph g on row r
    function automatic line_t ref_line(input glyph_num_t g, input row_idx_t r);
        int n;
        int lo;
        int hi;
        n  = int'(g);
        lo = 4 - n;
        hi = 3 + n;
        if (n == 0)
            return '0;
        if (n >= 5)
            return ((r == row_idx_t'(0)) || (r == row_idx_t'(7))) ? 8'hFF : 8'h81;
        if ((int'(r) < lo) || (int'(r) > hi))
            return '0;
        return line_t'(((1 << (2 * n)) - 1) << lo);    // 2n columns from lo
    endfunction

    function automatic row_idx_t idx_of_row(input line_t sel);
        row_idx_t idx;
        idx = '0;
        for (int i = 0; i < 8; i++)
        begin
            if (!sel[i])
                idx = row_idx_t'(i);
        end
        return idx;
    endfunction

    function automatic logic within_one_step(input row_idx_t a, input row_idx_t b);
        row_idx_t d;
        d = a - b;
        return (d == row_idx_t'(0)) || (d == row_idx_t'(1)) || (d == row_idx_t'(7));
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    always_comb
    begin
        exp_glyph = exp_ctrl_word[2:0];
        exp_red   = exp_ctrl_word[4];
        exp_green = exp_ctrl_word[5];
        pin_idx   = idx_of_row(row);
        exp_line  = ref_line(exp_glyph, pin_idx);
        exp_colr  = exp_red ? exp_line : '0;
        exp_colg  = exp_green ? exp_line : '0;
    end

    // control register model on the commit edge of each write
    always @(posedge clk)
    begin
        rst_d    <= rst;
        bvalid_d <= bvalid;
        rvalid_d <= rvalid;
        if (rst)
        begin
            exp_ctrl_word <= '0;
            blank_cnt     <= 2'd0;
        end
        else if (bvalid && !bvalid_d && wr_hits_ctrl)
        begin
            exp_ctrl_word <= wr_data_m & 32'h0000_0037;   // bits 0, 1, 2, 4 and 5 kept
            blank_cnt     <= 2'd2;
        end
        else if (blank_cnt != 2'd0)
            blank_cnt <= blank_cnt - 2'd1;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    a_reset_pins: assert property (@(posedge clk)
        rst_d |-> (row == 8'hFF) && (colr == 8'h00) && (colg == 8'h00) && !bvalid && !rvalid)
        else report_error("outputs not idle during reset");
    a_reset_ready: assert property (@(posedge clk)
        rst_d && !rst |=> awready && wready && arready)
        else report_error("ready signals did not rise after reset");
    a_one_row: assert property (@(posedge clk) disable iff (rst) $onehot0(~row))
        else report_error("more than one row selected");
    a_row_step: assert property (@(posedge clk) disable iff (rst)
        (row != row_d) && (row_d != 8'hFF) |-> row == {row_d[6:0], row_d[7]})
        else report_error("row select skipped or went backwards");
    a_pixels: assert property (@(posedge clk) disable iff (rst)
        (row != 8'hFF) && (blank_cnt == 2'd0) |-> (colr == exp_colr) && (colg == exp_colg))
        else report_error("column lines differ from glyph reference");
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else report_error("write response changed under back-pressure");
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else report_error("read response changed under back-pressure");
    a_b_single: assert property (@(posedge clk) disable iff (rst) bvalid && bready |=> !bvalid)
        else report_error("second write response issued");
    a_r_single: assert property (@(posedge clk) disable iff (rst) rvalid && rready |=> !rvalid)
        else report_error("second read response issued");
    a_b_blocks: assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready && !wready)
        else report_error("AW or W accepted while B pending");
    a_bresp: assert property (@(posedge clk) disable iff (rst)
        bvalid && bready |-> bresp == exp_bresp)
        else report_error("wrong bresp");
    a_rd_ctrl: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && (rd_kind == RD_CTRL) |-> (rresp == OKAY) && (rdata == exp_ctrl_word))
        else report_error("control register read back wrong");
    a_rd_stat: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rvalid_d && (rd_kind == RD_STAT)
        |-> (rresp == OKAY) && within_one_step(rdata[2:0], pin_idx))
        else report_error("status row index far from pins");
    a_rd_bad: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && (rd_kind == RD_BAD) |-> rresp == SLVERR)
        else report_error("unmapped read did not give SLVERR");

    always @(posedge clk)
        row_d <= row;

    task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
                             input logic [3:0] strb, input int order);
        logic aw_go;
        logic w_go;
        logic aw_done;
        logic w_done;
        int   stall;
        aw_done      = 1'b0;
        w_done       = 1'b0;
        wr_data_m    = data;
        wr_hits_ctrl = (addr == `DZ_CTRL_ADDR) && strb[0];
        exp_bresp    = (addr == `DZ_CTRL_ADDR) ? OKAY : SLVERR;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = (order != W_FIRST);
        wvalid  = (order != AW_FIRST);
        while (!(aw_done && w_done))
        begin
            aw_go = awvalid && awready;     // transfer on the coming edge
            w_go  = wvalid && wready;
            @(negedge clk);
            if (aw_go)
            begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_go)
            begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            if (aw_done && !w_done && !wvalid)
                wvalid = 1'b1;
            if (w_done && !aw_done && !awvalid)
                awvalid = 1'b1;
        end
        while (!bvalid)
            @(negedge clk);
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input axi_addr_t addr, input int kind);
        int stall;
        rd_kind = kind;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial
    begin
        axi_data_t rnd_data;
        int        rnd_order;
        clk          = 1'b0;
        rst          = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'h0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        rd_kind      = RD_BAD;
        wr_hits_ctrl = 1'b0;
        wr_data_m    = '0;
        exp_bresp    = OKAY;
        rst_d        = 1'b0;
        cycle_cnt    = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        // all three AW/W orderings with unused bits dropped
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0031, 4'h1, ORDER_BOTH);
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        write_reg(`DZ_CTRL_ADDR, 32'hFFFF_FFFF, 4'h1, AW_FIRST);
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0012, 4'hF, W_FIRST);
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0025, 4'h0, ORDER_BOTH);  // byte 0 not enabled
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);

        write_reg(`DZ_STAT_ADDR, 32'h0000_0027, 4'h1, ORDER_BOTH);
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        write_reg(axi_addr_t'(4'h8), 32'h0000_0033, 4'h1, AW_FIRST);
        write_reg(axi_addr_t'(4'hC), 32'h0000_0033, 4'h1, W_FIRST);
        read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        read_reg(axi_addr_t'(4'h8), RD_BAD);
        read_reg(axi_addr_t'(4'hC), RD_BAD);

        repeat (6)
        begin
            read_reg(`DZ_STAT_ADDR, RD_STAT);
            repeat ($unsigned($random(seed)) % 5) @(negedge clk);
        end

        for (int g = 0; g < 8; g++)
        begin
            write_reg(`DZ_CTRL_ADDR, axi_data_t'(32'h30 | g), 4'h1, g % 3);
            repeat (3 * FRAME_CYCLES) @(negedge clk);
        end

        // color enables on the full square and the border
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0014, 4'h1, ORDER_BOTH);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0024, 4'h1, AW_FIRST);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0016, 4'h1, W_FIRST);
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        write_reg(`DZ_CTRL_ADDR, 32'h0000_0004, 4'h1, ORDER_BOTH);
        repeat (2 * FRAME_CYCLES) @(negedge clk);

        repeat (6)
        begin
            rnd_data  = $random(seed);
            rnd_order = $unsigned($random(seed)) % 3;
            write_reg(`DZ_CTRL_ADDR, rnd_data, 4'h1, rnd_order);
            read_reg(`DZ_CTRL_ADDR, RD_CTRL);
        end
        repeat (FRAME_CYCLES) @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
